// ==== logic/soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 30
`define SOC_SEL_W 4

// scratch RAM word index width, 256 words
`define SOC_RAM_AW 8

// read back at system register offset 0
`define SOC_ID_WORD 32'h20191028

// region tag, compared against word address bits 29:21
`define SOC_SYSREG_BASE 9'h1

// switch/LED port sits at one word address
`define SOC_LEDSW_ADDR 30'h400001

// system register offsets
`define SOC_SYSREG_ID 4'h0
`define SOC_SYSREG_SCRATCH 4'h1
`define SOC_SYSREG_ERRADDR 4'h2
`define SOC_SYSREG_POWER 4'h3
`define SOC_SYSREG_IRQ 4'h4

`endif

// ==== logic/soc_pkg.sv ====
`default_nettype none

`include "soc_macros.svh"

package soc_pkg;

    // one bus data word
    typedef logic [`SOC_DATA_W-1:0] wb_data_t;

    // word address, byte offset bits dropped
    typedef logic [`SOC_ADDR_W-1:0] wb_addr_t;

    // byte lane enables
    typedef logic [`SOC_SEL_W-1:0] wb_sel_t;

    // scratch RAM word index
    typedef logic [`SOC_RAM_AW-1:0] ram_index_t;

    // which master holds the bus
    typedef enum logic [1:0] {
        owner_none,
        owner_a,
        owner_b
    } arb_owner_e;

endpackage : soc_pkg

`default_nettype wire

// ==== logic/wb_pri_arbiter.sv ====
`default_nettype none

module wb_pri_arbiter (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    // master A, higher priority
    input  wire logic              i_a_cyc,
    input  wire logic              i_a_stb,
    input  wire logic              i_a_we,
    input  wire soc_pkg::wb_addr_t i_a_adr,
    input  wire soc_pkg::wb_data_t i_a_dat,
    input  wire soc_pkg::wb_sel_t  i_a_sel,
    output logic                   o_a_ack,
    output logic                   o_a_err,
    // master B
    input  wire logic              i_b_cyc,
    input  wire logic              i_b_stb,
    input  wire logic              i_b_we,
    input  wire soc_pkg::wb_addr_t i_b_adr,
    input  wire soc_pkg::wb_data_t i_b_dat,
    input  wire soc_pkg::wb_sel_t  i_b_sel,
    output logic                   o_b_ack,
    output logic                   o_b_err,
    // merged master bus
    output logic                   o_m_cyc,
    output logic                   o_m_stb,
    output logic                   o_m_we,
    output soc_pkg::wb_addr_t      o_m_adr,
    output soc_pkg::wb_data_t      o_m_dat,
    output soc_pkg::wb_sel_t       o_m_sel,
    input  wire logic              i_m_ack,
    input  wire logic              i_m_err
);

    soc_pkg::arb_owner_e owner;
    soc_pkg::arb_owner_e owner_next;

    // regrant only when idle or when the owner has let go of cyc
    always_comb begin
        owner_next = owner;
        if (owner == soc_pkg::owner_none || !o_m_cyc) begin
            if (i_a_cyc)
                owner_next = soc_pkg::owner_a;
            else if (i_b_cyc)
                owner_next = soc_pkg::owner_b;
            else
                owner_next = soc_pkg::owner_none;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            owner <= soc_pkg::owner_none;
        else
            owner <= owner_next;
    end

    // owner's request goes straight through
    always_comb begin
        case (owner)
            soc_pkg::owner_a: begin
                o_m_cyc = i_a_cyc;
                o_m_stb = i_a_stb;
                o_m_we  = i_a_we;
                o_m_adr = i_a_adr;
                o_m_dat = i_a_dat;
                o_m_sel = i_a_sel;
            end
            soc_pkg::owner_b: begin
                o_m_cyc = i_b_cyc;
                o_m_stb = i_b_stb;
                o_m_we  = i_b_we;
                o_m_adr = i_b_adr;
                o_m_dat = i_b_dat;
                o_m_sel = i_b_sel;
            end
            default: begin
                o_m_cyc = 1'b0;
                o_m_stb = 1'b0;
                o_m_we  = 1'b0;
                o_m_adr = '0;
                o_m_dat = '0;
                o_m_sel = '0;
            end
        endcase
    end

    // responses only reach the master that owns the bus
    assign o_a_ack = (owner == soc_pkg::owner_a) && i_a_cyc && i_m_ack;
    assign o_a_err = (owner == soc_pkg::owner_a) && i_a_cyc && i_m_err;
    assign o_b_ack = (owner == soc_pkg::owner_b) && i_b_cyc && i_m_ack;
    assign o_b_err = (owner == soc_pkg::owner_b) && i_b_cyc && i_m_err;

    // an owner keeps the bus for as long as it holds cyc
    a_owner_held : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (owner != soc_pkg::owner_none && o_m_cyc) |=> (owner == $past(owner)));

endmodule : wb_pri_arbiter

`default_nettype wire

// ==== logic/bus_decoder.sv ====
`default_nettype none

`include "soc_macros.svh"

module bus_decoder (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_m_stb,
    input  wire soc_pkg::wb_addr_t i_m_adr,
    // device strobes
    output logic                   o_ram_stb,
    output logic                   o_sysreg_stb,
    output logic                   o_ledsw_stb,
    // device responses
    input  wire logic              i_ram_ack,
    input  wire logic              i_sysreg_ack,
    input  wire logic              i_ledsw_ack,
    input  wire soc_pkg::wb_data_t i_ram_dat,
    input  wire soc_pkg::wb_data_t i_sysreg_dat,
    input  wire soc_pkg::wb_data_t i_ledsw_dat,
    // merged response to the master bus
    output logic                   o_m_ack,
    output logic                   o_m_err,
    output soc_pkg::wb_data_t      o_m_dat
);

    logic ram_sel;
    logic sysreg_sel;
    logic ledsw_sel;
    logic none_sel;

    // RAM aliases over its whole region, only the low index bits are used
    assign ram_sel    = (i_m_adr[`SOC_ADDR_W-1:21] == '0);
    assign sysreg_sel = (i_m_adr[`SOC_ADDR_W-1:21] == `SOC_SYSREG_BASE);
    assign ledsw_sel  = (i_m_adr == `SOC_LEDSW_ADDR);
    assign none_sel   = !ram_sel && !sysreg_sel && !ledsw_sel;

    assign o_ram_stb    = i_m_stb && ram_sel;
    assign o_sysreg_stb = i_m_stb && sysreg_sel;
    assign o_ledsw_stb  = i_m_stb && ledsw_sel;

    // unmapped strobe, same one-cycle timing as a device ack
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_m_err <= 1'b0;
        else
            o_m_err <= i_m_stb && none_sel && !o_m_err;
    end

    assign o_m_ack = i_ram_ack || i_sysreg_ack || i_ledsw_ack;

    // at most one device acks at a time
    always_comb begin
        if (i_ram_ack)
            o_m_dat = i_ram_dat;
        else if (i_sysreg_ack)
            o_m_dat = i_sysreg_dat;
        else if (i_ledsw_ack)
            o_m_dat = i_ledsw_dat;
        else
            o_m_dat = '0;
    end

    a_ack_err_excl : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_m_ack && o_m_err));

endmodule : bus_decoder

`default_nettype wire

// ==== logic/sys_regs.sv ====
`default_nettype none

`include "soc_macros.svh"

module sys_regs (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_stb,
    input  wire logic              i_we,
    input  wire soc_pkg::wb_addr_t i_adr,
    input  wire soc_pkg::wb_data_t i_dat,
    input  wire logic              i_bus_err,
    output logic                   o_ack,
    output soc_pkg::wb_data_t      o_dat,
    output logic                   o_irq
);

    soc_pkg::wb_data_t scratch;
    soc_pkg::wb_data_t power_cnt;
    soc_pkg::wb_addr_t err_addr;

    // one ack per strobe, even if the strobe is held
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack     <= 1'b0;
            o_irq     <= 1'b0;
            err_addr  <= '0;
            power_cnt <= '0;
        end else begin
            o_ack <= i_stb && !o_ack;
            if (i_stb && i_we && i_adr[3:0] == `SOC_SYSREG_IRQ)
                o_irq <= i_dat[0];
            // address is still held by the master during the err cycle
            if (i_bus_err)
                err_addr <= i_adr;
            // top bit sticks once reached
            if (!power_cnt[`SOC_DATA_W-1])
                power_cnt <= power_cnt + 1'b1;
            else
                power_cnt[`SOC_DATA_W-2:0] <= power_cnt[`SOC_DATA_W-2:0] + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb && i_we && i_adr[3:0] == `SOC_SYSREG_SCRATCH)
            scratch <= i_dat;
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (i_adr[3:0])
                `SOC_SYSREG_ID:      o_dat <= `SOC_ID_WORD;
                `SOC_SYSREG_SCRATCH: o_dat <= scratch;
                `SOC_SYSREG_ERRADDR: o_dat <= {err_addr, 2'b00};
                `SOC_SYSREG_POWER:   o_dat <= power_cnt;
                `SOC_SYSREG_IRQ:     o_dat <= {{(`SOC_DATA_W-1){1'b0}}, o_irq};
                default:             o_dat <= '0;
            endcase
        end
    end

endmodule : sys_regs

`default_nettype wire

// ==== logic/led_switch_port.sv ====
`default_nettype none

module led_switch_port (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_stb,
    input  wire logic              i_we,
    input  wire soc_pkg::wb_data_t i_dat,
    input  wire logic [15:0]       i_switches,
    output logic                   o_ack,
    output soc_pkg::wb_data_t      o_dat,
    output logic [15:0]            o_leds
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack  <= 1'b0;
            o_leds <= '0;
        end else begin
            o_ack <= i_stb && !o_ack;
            // LEDs take the low half of the write data
            if (i_stb && i_we)
                o_leds <= i_dat[15:0];
        end
    end

    // switches sampled on every strobe, upper half reads zero
    always_ff @(posedge i_clk) begin
        if (i_stb)
            o_dat <= {16'h0000, i_switches};
    end

endmodule : led_switch_port

`default_nettype wire

// ==== logic/scratch_ram.sv ====
`default_nettype none

`include "soc_macros.svh"

module scratch_ram (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_stb,
    input  wire logic                i_we,
    input  wire soc_pkg::ram_index_t i_adr,
    input  wire soc_pkg::wb_data_t   i_dat,
    input  wire soc_pkg::wb_sel_t    i_sel,
    output logic                     o_ack,
    output soc_pkg::wb_data_t        o_dat
);

    soc_pkg::wb_data_t mem [2**`SOC_RAM_AW];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_ack <= 1'b0;
        else
            o_ack <= i_stb && !o_ack;
    end

    // per-lane write, registered read of the old word
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            if (i_we) begin
                for (int lane = 0; lane < `SOC_SEL_W; lane++) begin
                    if (i_sel[lane])
                        mem[i_adr][lane*8 +: 8] <= i_dat[lane*8 +: 8];
                end
            end
            o_dat <= mem[i_adr];
        end
    end

    a_ack_needs_stb : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_stb |=> !o_ack);

endmodule : scratch_ram

`default_nettype wire

// ==== logic/soc_bus_top.sv ====
`default_nettype none

`include "soc_macros.svh"

module soc_bus_top (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    // master A, processor side
    input  wire logic              i_a_cyc,
    input  wire logic              i_a_stb,
    input  wire logic              i_a_we,
    input  wire soc_pkg::wb_addr_t i_a_adr,
    input  wire soc_pkg::wb_data_t i_a_dat,
    input  wire soc_pkg::wb_sel_t  i_a_sel,
    output logic                   o_a_ack,
    output logic                   o_a_err,
    // master B, debug side
    input  wire logic              i_b_cyc,
    input  wire logic              i_b_stb,
    input  wire logic              i_b_we,
    input  wire soc_pkg::wb_addr_t i_b_adr,
    input  wire soc_pkg::wb_data_t i_b_dat,
    input  wire soc_pkg::wb_sel_t  i_b_sel,
    output logic                   o_b_ack,
    output logic                   o_b_err,
    output soc_pkg::wb_data_t      o_rd_dat,
    input  wire logic [15:0]       i_switches,
    output logic [15:0]            o_leds,
    output logic                   o_irq
);

    // master bus
    logic              m_cyc;
    logic              m_stb;
    logic              m_we;
    soc_pkg::wb_addr_t m_adr;
    soc_pkg::wb_data_t m_dat;
    soc_pkg::wb_sel_t  m_sel;
    logic              m_ack;
    logic              m_err;

    // device side
    logic              ram_stb;
    logic              sysreg_stb;
    logic              ledsw_stb;
    logic              ram_ack;
    logic              sysreg_ack;
    logic              ledsw_ack;
    soc_pkg::wb_data_t ram_dat;
    soc_pkg::wb_data_t sysreg_dat;
    soc_pkg::wb_data_t ledsw_dat;

    wb_pri_arbiter wb_pri_arbiter_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_a_cyc(i_a_cyc), .i_a_stb(i_a_stb), .i_a_we(i_a_we),
        .i_a_adr(i_a_adr), .i_a_dat(i_a_dat), .i_a_sel(i_a_sel),
        .o_a_ack(o_a_ack), .o_a_err(o_a_err),
        .i_b_cyc(i_b_cyc), .i_b_stb(i_b_stb), .i_b_we(i_b_we),
        .i_b_adr(i_b_adr), .i_b_dat(i_b_dat), .i_b_sel(i_b_sel),
        .o_b_ack(o_b_ack), .o_b_err(o_b_err),
        .o_m_cyc(m_cyc), .o_m_stb(m_stb), .o_m_we(m_we),
        .o_m_adr(m_adr), .o_m_dat(m_dat), .o_m_sel(m_sel),
        .i_m_ack(m_ack), .i_m_err(m_err)
    );

    // a strobe only counts inside a bus cycle
    bus_decoder bus_decoder_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_m_stb(m_cyc && m_stb), .i_m_adr(m_adr),
        .o_ram_stb(ram_stb), .o_sysreg_stb(sysreg_stb), .o_ledsw_stb(ledsw_stb),
        .i_ram_ack(ram_ack), .i_sysreg_ack(sysreg_ack), .i_ledsw_ack(ledsw_ack),
        .i_ram_dat(ram_dat), .i_sysreg_dat(sysreg_dat), .i_ledsw_dat(ledsw_dat),
        .o_m_ack(m_ack), .o_m_err(m_err), .o_m_dat(o_rd_dat)
    );

    sys_regs sys_regs_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_stb(sysreg_stb), .i_we(m_we), .i_adr(m_adr), .i_dat(m_dat),
        .i_bus_err(m_err),
        .o_ack(sysreg_ack), .o_dat(sysreg_dat), .o_irq(o_irq)
    );

    led_switch_port led_switch_port_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_stb(ledsw_stb), .i_we(m_we), .i_dat(m_dat), .i_switches(i_switches),
        .o_ack(ledsw_ack), .o_dat(ledsw_dat), .o_leds(o_leds)
    );

    scratch_ram scratch_ram_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_stb(ram_stb), .i_we(m_we), .i_adr(m_adr[`SOC_RAM_AW-1:0]),
        .i_dat(m_dat), .i_sel(m_sel),
        .o_ack(ram_ack), .o_dat(ram_dat)
    );

endmodule : soc_bus_top

`default_nettype wire

// ==== tb/tb_soc_bus.sv ====
`default_nettype none

`include "soc_macros.svh"

module tb_soc_bus;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int rsp_limit = 20;
    localparam int kind_resp = 1;
    localparam int kind_leds = 2;
    localparam int kind_irq = 3;
    localparam int kind_power = 4;
    localparam int kind_order = 5;

    logic clk;
    logic rst_n;
    logic a_cyc, a_stb, a_we, a_ack, a_err;
    logic b_cyc, b_stb, b_we, b_ack, b_err;
    soc_pkg::wb_addr_t a_adr, b_adr;
    soc_pkg::wb_data_t a_dat, b_dat, rd_dat;
    soc_pkg::wb_sel_t a_sel, b_sel;
    logic [15:0] switches, leds;
    logic irq;

    // check state, sampled by the assertions below
    int chk_kind = 0;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    logic got_ack, got_err, exp_ack, exp_err, dat_en, exp_irq, contest;
    soc_pkg::wb_data_t got_dat, exp_dat, power_first, power_second;
    logic [15:0] exp_leds;
    time a_done_t, b_done_t;
    soc_pkg::wb_data_t ref_mem [2**`SOC_RAM_AW];
    logic [31:0] rng_state = 32'h3e260da9;

    soc_bus_top soc_bus_top_i (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_a_cyc(a_cyc), .i_a_stb(a_stb), .i_a_we(a_we),
        .i_a_adr(a_adr), .i_a_dat(a_dat), .i_a_sel(a_sel),
        .o_a_ack(a_ack), .o_a_err(a_err),
        .i_b_cyc(b_cyc), .i_b_stb(b_stb), .i_b_we(b_we),
        .i_b_adr(b_adr), .i_b_dat(b_dat), .i_b_sel(b_sel),
        .o_b_ack(b_ack), .o_b_err(b_err),
        .o_rd_dat(rd_dat), .i_switches(switches), .o_leds(leds), .o_irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit
    initial begin
        repeat (20000) @(posedge clk);
        $display("simulation ran past its cycle limit");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // upper bits land in the RAM alias range
    function automatic soc_pkg::wb_addr_t ram_addr(input soc_pkg::ram_index_t idx,
                                                   input logic [12:0] alias_bits);
        return {9'h000, alias_bits, idx};
    endfunction

    function automatic soc_pkg::wb_addr_t sysreg_addr(input logic [3:0] off);
        return {`SOC_SYSREG_BASE, 17'h00000, off};
    endfunction

    task automatic a_access(input logic we, input soc_pkg::wb_addr_t adr,
                            input soc_pkg::wb_data_t dat, input soc_pkg::wb_sel_t sel,
                            output logic ack, output logic err,
                            output soc_pkg::wb_data_t rdat);
        int waited;
        ack = 1'b0;
        err = 1'b0;
        rdat = '0;
        waited = 0;
        a_cyc = 1'b1;
        a_stb = 1'b1;
        a_we = we;
        a_adr = adr;
        a_dat = dat;
        a_sel = sel;
        // responses are stable mid-cycle
        while (!ack && !err && waited < rsp_limit) begin
            @(negedge clk);
            ack = a_ack;
            err = a_err;
            rdat = rd_dat;
            waited++;
        end
        if (!ack && !err) begin
            timeouts++;
            $display("master A saw no response at address %h", adr);
        end
        @(posedge clk);
        #1;
        a_cyc = 1'b0;
        a_stb = 1'b0;
        a_we = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic b_access(input logic we, input soc_pkg::wb_addr_t adr,
                            input soc_pkg::wb_data_t dat, input soc_pkg::wb_sel_t sel,
                            output logic ack, output logic err,
                            output soc_pkg::wb_data_t rdat);
        int waited;
        ack = 1'b0;
        err = 1'b0;
        rdat = '0;
        waited = 0;
        b_cyc = 1'b1;
        b_stb = 1'b1;
        b_we = we;
        b_adr = adr;
        b_dat = dat;
        b_sel = sel;
        while (!ack && !err && waited < rsp_limit) begin
            @(negedge clk);
            ack = b_ack;
            err = b_err;
            rdat = rd_dat;
            waited++;
        end
        if (!ack && !err) begin
            timeouts++;
            $display("master B saw no response at address %h", adr);
        end
        @(posedge clk);
        #1;
        b_cyc = 1'b0;
        b_stb = 1'b0;
        b_we = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic bus_access(input logic use_b, input logic we,
                              input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t dat,
                              input soc_pkg::wb_sel_t sel, output logic ack,
                              output logic err, output soc_pkg::wb_data_t rdat);
        if (use_b)
            b_access(we, adr, dat, sel, ack, err, rdat);
        else
            a_access(we, adr, dat, sel, ack, err, rdat);
    endtask

    // holds a check kind for one rising edge
    task automatic run_check(input int kind);
        chk_kind = kind;
        checks++;
        @(posedge clk);
        #1;
        chk_kind = 0;
    endtask

    task automatic expect_resp(input logic ack, input logic err, input soc_pkg::wb_data_t rdat,
                               input logic e_ack, input logic e_err, input logic cmp_dat,
                               input soc_pkg::wb_data_t e_dat);
        got_ack = ack;
        got_err = err;
        got_dat = rdat;
        exp_ack = e_ack;
        exp_err = e_err;
        dat_en = cmp_dat;
        exp_dat = e_dat;
        run_check(kind_resp);
    endtask

    ack_match : assert property (@(posedge clk) chk_kind == kind_resp |-> got_ack == exp_ack)
        else begin
            errors++;
            $display("** Error %0t: ack is %b, expected %b", $time, got_ack, exp_ack);
        end
    err_match : assert property (@(posedge clk) chk_kind == kind_resp |-> got_err == exp_err)
        else begin
            errors++;
            $display("** Error %0t: err is %b, expected %b", $time, got_err, exp_err);
        end
    dat_match : assert property (@(posedge clk)
        chk_kind == kind_resp && dat_en |-> got_dat == exp_dat)
        else begin
            errors++;
            $display("** Error %0t: rd_dat is %h, expected %h", $time, got_dat, exp_dat);
        end
    leds_match : assert property (@(posedge clk) chk_kind == kind_leds |-> leds == exp_leds)
        else begin
            errors++;
            $display("** Error %0t: leds is %h, expected %h", $time, leds, exp_leds);
        end
    irq_match : assert property (@(posedge clk) chk_kind == kind_irq |-> irq == exp_irq)
        else begin
            errors++;
            $display("** Error %0t: irq is %b, expected %b", $time, irq, exp_irq);
        end
    power_rises : assert property (@(posedge clk)
        chk_kind == kind_power |-> power_second > power_first)
        else begin
            errors++;
            $display("** Error %0t: power counter is %h, expected above %h",
                     $time, power_second, power_first);
        end
    a_first : assert property (@(posedge clk) chk_kind == kind_order |-> a_done_t < b_done_t)
        else begin
            errors++;
            $display("master B finished before master A in a contested start");
        end
    b_held_off : assert property (@(posedge clk) contest && a_cyc |-> !(b_ack || b_err))
        else begin
            errors++;
            $display("master B got a response while master A held the bus");
        end
    a_quiet : assert property (@(posedge clk) !a_cyc |-> !(a_ack || a_err))
        else begin
            errors++;
            $display("master A got a response with its cyc low");
        end
    b_quiet : assert property (@(posedge clk) !b_cyc |-> !(b_ack || b_err))
        else begin
            errors++;
            $display("master B got a response with its cyc low");
        end
    single_resp : assert property (@(posedge clk) !(a_ack && a_err) && !(b_ack && b_err))
        else begin
            errors++;
            $display("a transfer got ack and err together");
        end

    initial begin
        logic ack, err, a_ack_r, a_err_r, b_ack_r, b_err_r;
        soc_pkg::wb_data_t rdat, d, r, a_dat_r, b_dat_r;
        soc_pkg::wb_addr_t adr;
        soc_pkg::ram_index_t idx;
        soc_pkg::ram_index_t idx_list [16];
        rst_n = 1'b0;
        {a_cyc, a_stb, a_we, b_cyc, b_stb, b_we} = '0;
        a_adr = '0;
        b_adr = '0;
        a_dat = '0;
        b_dat = '0;
        a_sel = '0;
        b_sel = '0;
        switches = '0;
        contest = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;

        // fill some RAM words so every lane is known
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            d = next_rand();
            idx_list[i] = r[7:0];
            bus_access(r[31], 1'b1, ram_addr(r[7:0], r[20:8]), d, 4'hf, ack, err, rdat);
            ref_mem[r[7:0]] = d;
            expect_resp(ack, err, rdat, 1'b1, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            d = next_rand();
            idx = idx_list[r[3:0]];
            bus_access(r[8], 1'b1, ram_addr(idx, r[21:9]), d, r[7:4], ack, err, rdat);
            for (int lane = 0; lane < 4; lane++) begin
                if (r[4 + lane])
                    ref_mem[idx][lane*8 +: 8] = d[lane*8 +: 8];
            end
            expect_resp(ack, err, rdat, 1'b1, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            bus_access(r[0], 1'b0, ram_addr(idx_list[i], r[13:1]), '0, 4'hf, ack, err, rdat);
            expect_resp(ack, err, rdat, 1'b1, 1'b0, 1'b1, ref_mem[idx_list[i]]);
        end

        // system registers
        bus_access(1'b0, 1'b0, sysreg_addr(`SOC_SYSREG_ID), '0, 4'hf, ack, err, rdat);
        expect_resp(ack, err, rdat, 1'b1, 1'b0, 1'b1, `SOC_ID_WORD);
        bus_access(1'b1, 1'b1, sysreg_addr(`SOC_SYSREG_SCRATCH), next_rand(), 4'hf,
                   ack, err, rdat);
        d = next_rand();
        bus_access(1'b0, 1'b1, sysreg_addr(`SOC_SYSREG_SCRATCH), d, 4'hf, ack, err, rdat);
        bus_access(1'b1, 1'b0, sysreg_addr(`SOC_SYSREG_SCRATCH), '0, 4'hf, ack, err, rdat);
        expect_resp(ack, err, rdat, 1'b1, 1'b0, 1'b1, d);
        r = next_rand();
        bus_access(1'b0, 1'b1, sysreg_addr(`SOC_SYSREG_IRQ), {r[31:1], 1'b1}, 4'hf,
                   ack, err, rdat);
        exp_irq = 1'b1;
        run_check(kind_irq);
        bus_access(1'b1, 1'b1, sysreg_addr(`SOC_SYSREG_IRQ), {r[31:1], 1'b0}, 4'hf,
                   ack, err, rdat);
        exp_irq = 1'b0;
        run_check(kind_irq);

        // unmapped region, tags 0x100 and up
        r = next_rand();
        adr = {r[8:0] | 9'h100, r[29:9]};
        bus_access(r[30], 1'b0, adr, '0, 4'hf, ack, err, rdat);
        expect_resp(ack, err, rdat, 1'b0, 1'b1, 1'b0, '0);
        bus_access(1'b0, 1'b0, sysreg_addr(`SOC_SYSREG_ERRADDR), '0, 4'hf, ack, err, rdat);
        expect_resp(ack, err, rdat, 1'b1, 1'b0, 1'b1, {adr, 2'b00});
        bus_access(1'b0, 1'b0, sysreg_addr(`SOC_SYSREG_POWER), '0, 4'hf, ack, err, rdat);
        power_first = rdat;
        repeat (5) @(posedge clk);
        #1;
        bus_access(1'b1, 1'b0, sysreg_addr(`SOC_SYSREG_POWER), '0, 4'hf, ack, err, rdat);
        power_second = rdat;
        run_check(kind_power);

        // switch/LED port
        r = next_rand();
        bus_access(1'b1, 1'b1, `SOC_LEDSW_ADDR, r, 4'hf, ack, err, rdat);
        expect_resp(ack, err, rdat, 1'b1, 1'b0, 1'b0, '0);
        exp_leds = r[15:0];
        run_check(kind_leds);
        r = next_rand();
        switches = r[31:16];
        bus_access(1'b0, 1'b0, `SOC_LEDSW_ADDR, '0, 4'hf, ack, err, rdat);
        expect_resp(ack, err, rdat, 1'b1, 1'b0, 1'b1, {16'h0000, r[31:16]});

        // both masters start together from idle
        contest = 1'b1;
        fork
            begin
                a_access(1'b0, ram_addr(idx_list[2], '0), '0, 4'hf, a_ack_r, a_err_r, a_dat_r);
                a_done_t = $time;
            end
            begin
                b_access(1'b0, ram_addr(idx_list[3], '1), '0, 4'hf, b_ack_r, b_err_r, b_dat_r);
                b_done_t = $time;
            end
        join
        contest = 1'b0;
        expect_resp(a_ack_r, a_err_r, a_dat_r, 1'b1, 1'b0, 1'b1, ref_mem[idx_list[2]]);
        expect_resp(b_ack_r, b_err_r, b_dat_r, 1'b1, 1'b0, 1'b1, ref_mem[idx_list[3]]);
        run_check(kind_order);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_soc_bus

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/soc_pkg.sv
logic/wb_pri_arbiter.sv
logic/bus_decoder.sv
logic/sys_regs.sv
logic/led_switch_port.sv
logic/scratch_ram.sv
logic/soc_bus_top.sv
tb/tb_soc_bus.sv
